// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // Architectural widths
    localparam int XLEN         = 64;
    localparam int REG_IDX_W    = 5;
    localparam int INSTRET_W    = 64;

    // Up to four retirements per cycle, so three bits
    localparam int RETIRE_CNT_W = 3;

    // Integer register file depth, x0 included
    localparam int NUM_REGS     = 32;

    // Producers feeding writeback: md, lsp, ip, trap
    localparam int NUM_SRC      = 4;

    typedef logic [XLEN-1:0]         xlen_t;
    typedef logic [REG_IDX_W-1:0]    reg_idx_t;
    typedef logic [RETIRE_CNT_W-1:0] retire_cnt_t;
    typedef logic [INSTRET_W-1:0]    instret_t;

endpackage

`default_nettype wire

// ==== logic/wb_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_arbiter
    import core_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    // Integer pipe
    input  wire              ip_valid,
    input  wire              ip_wb_en,
    input  wire              ip_hipri,
    input  wire reg_idx_t    ip_dst,
    input  wire xlen_t       ip_result,
    output logic             ip_ready,
    // Load-store pipe
    input  wire              lsp_valid,
    input  wire              lsp_wb_en,
    input  wire reg_idx_t    lsp_dst,
    input  wire xlen_t       lsp_result,
    output logic             lsp_ready,
    // Multiply-divide always writes a register
    input  wire              md_valid,
    input  wire reg_idx_t    md_dst,
    input  wire xlen_t       md_result,
    output logic             md_ready,
    // Trap unit
    input  wire              trap_valid,
    input  wire              trap_wb_en,
    input  wire reg_idx_t    trap_dst,
    input  wire xlen_t       trap_result,
    output logic             trap_ready,
    // Register file write port
    output logic             rf_wen,
    output reg_idx_t         rf_wdst,
    output xlen_t            rf_wdata,
    // Collision buffer as seen by issue
    output logic             fwd_valid,
    output reg_idx_t         fwd_dst,
    output xlen_t            fwd_value,
    // Retirements of the previous cycle
    output retire_cnt_t      retire_cnt
);

    // One-entry collision buffer
    logic        buf_valid;
    reg_idx_t    buf_dst;
    xlen_t       buf_value;

    // Write requests per producer
    // An offer with wb_en low only retires
    logic        ip_req;
    logic        lsp_req;
    logic        md_req;
    logic        trap_req;

    logic        md_grant;
    logic        buf_grant;
    logic        lsp_grant;
    logic        ip_grant;
    logic        trap_grant;

    logic        buf_free;
    logic        lsp_to_buf;
    logic        ip_to_buf;

    // Handshake per producer with md in bit 0, then lsp, ip and trap
    logic [NUM_SRC-1:0] handshake;
    retire_cnt_t        hs_cnt;

    assign ip_req   = ip_valid && ip_wb_en;
    assign lsp_req  = lsp_valid && lsp_wb_en;
    assign md_req   = md_valid;
    assign trap_req = trap_valid && trap_wb_en;

    // Fixed order md > buf > lsp > ip > trap
    // ip_hipri pushes ip ahead of md, buf and lsp
    assign md_grant   = md_req && !ip_hipri;
    assign buf_grant  = buf_valid && !md_grant && !ip_hipri;
    assign lsp_grant  = lsp_req && !md_grant && !buf_grant && !ip_hipri;
    assign ip_grant   = ip_req && !md_grant && !buf_grant && !lsp_grant;
    assign trap_grant = trap_req && !md_grant && !buf_grant && !lsp_grant && !ip_grant;

    // Buffer takes a loser if empty or emptied this cycle
    assign buf_free   = !buf_valid || buf_grant;
    // lsp gets first claim
    assign lsp_to_buf = lsp_req && !lsp_grant && buf_free;
    assign ip_to_buf  = ip_req && !ip_grant && !lsp_to_buf && buf_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (lsp_to_buf || ip_to_buf) begin
            buf_valid <= 1'b1;
        end else if (buf_grant) begin
            buf_valid <= 1'b0;
        end
    end

    // Payload of the captured loser
    always_ff @(posedge clk) begin
        if (lsp_to_buf) begin
            buf_dst   <= lsp_dst;
            buf_value <= lsp_result;
        end else if (ip_to_buf) begin
            buf_dst   <= ip_dst;
            buf_value <= ip_result;
        end
    end

    assign fwd_valid = buf_valid;
    assign fwd_dst   = buf_dst;
    assign fwd_value = buf_value;

    // Write port mux in grant priority order
    always_comb begin
        rf_wen   = md_grant || buf_grant || lsp_grant || ip_grant || trap_grant;
        rf_wdst  = '0;
        rf_wdata = '0;
        if (md_grant) begin
            rf_wdst  = md_dst;
            rf_wdata = md_result;
        end else if (buf_grant) begin
            rf_wdst  = buf_dst;
            rf_wdata = buf_value;
        end else if (lsp_grant) begin
            rf_wdst  = lsp_dst;
            rf_wdata = lsp_result;
        end else if (ip_grant) begin
            rf_wdst  = ip_dst;
            rf_wdata = ip_result;
        end else if (trap_grant) begin
            rf_wdst  = trap_dst;
            rf_wdata = trap_result;
        end
    end

    // Ready on a grant or a buffer capture or a retire without writeback
    assign md_ready   = !md_valid || md_grant;
    assign lsp_ready  = !lsp_valid || !lsp_wb_en || lsp_grant || lsp_to_buf;
    assign ip_ready   = !ip_valid || !ip_wb_en || ip_grant || ip_to_buf;
    assign trap_ready = !trap_valid || !trap_wb_en || trap_grant;

    // A buffer drain was already counted at capture
    assign handshake = {trap_valid && trap_ready,
                        ip_valid && ip_ready,
                        lsp_valid && lsp_ready,
                        md_grant};

    always_comb begin
        hs_cnt = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            hs_cnt = hs_cnt + retire_cnt_t'(handshake[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_cnt <= '0;
        end else begin
            retire_cnt <= hs_cnt;
        end
    end

    // At most one winner on the single write port
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({trap_grant, ip_grant, lsp_grant, buf_grant, md_grant}));

    // Held entry stays put until it drains
    assert property (@(posedge clk) disable iff (rst)
        (buf_valid && !buf_grant) |=>
            (buf_valid && $stable(buf_dst) && $stable(buf_value)));

    // md only stalls with an offer pending behind a high priority ip
    assert property (@(posedge clk) disable iff (rst)
        !md_ready |-> (md_valid && ip_hipri));

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    // Write port from writeback
    input  wire              wen,
    input  wire reg_idx_t    wdst,
    input  wire xlen_t       wdata,
    // Read ports standing in for issue
    input  wire reg_idx_t    raddr_a,
    input  wire reg_idx_t    raddr_b,
    output xlen_t            rdata_a,
    output xlen_t            rdata_b
);

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wdst != '0)) begin
            // x0 is never written
            regs[wdst] <= wdata;
        end
    end

    // Combinational reads, new data visible after the write edge
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    // x0 holds zero through any write traffic
    assert property (@(posedge clk) disable iff (rst)
        (raddr_a == '0) |-> (rdata_a == '0));

    assert property (@(posedge clk) disable iff (rst)
        (raddr_b == '0) |-> (rdata_b == '0));

endmodule

`default_nettype wire

// ==== logic/retire_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module retire_counter
    import core_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    // Retirements counted by the arbiter last cycle
    input  wire retire_cnt_t retire_cnt,
    // Running minstret value
    output instret_t         instret
);

    always_ff @(posedge clk) begin
        if (rst) begin
            instret <= '0;
        end else begin
            instret <= instret + instret_t'(retire_cnt);
        end
    end

    // Monotonic outside reset
    assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (instret >= $past(instret)));

endmodule

`default_nettype wire

// ==== logic/wb_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_stage
    import core_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    // Integer pipe
    input  wire              ip_valid,
    input  wire              ip_wb_en,
    input  wire              ip_hipri,
    input  wire reg_idx_t    ip_dst,
    input  wire xlen_t       ip_result,
    output logic             ip_ready,
    // Load-store pipe
    input  wire              lsp_valid,
    input  wire              lsp_wb_en,
    input  wire reg_idx_t    lsp_dst,
    input  wire xlen_t       lsp_result,
    output logic             lsp_ready,
    // Multiply-divide
    input  wire              md_valid,
    input  wire reg_idx_t    md_dst,
    input  wire xlen_t       md_result,
    output logic             md_ready,
    // Trap unit
    input  wire              trap_valid,
    input  wire              trap_wb_en,
    input  wire reg_idx_t    trap_dst,
    input  wire xlen_t       trap_result,
    output logic             trap_ready,
    // Forwarding to issue
    output logic             fwd_valid,
    output reg_idx_t         fwd_dst,
    output xlen_t            fwd_value,
    // Register reads
    input  wire reg_idx_t    raddr_a,
    input  wire reg_idx_t    raddr_b,
    output xlen_t            rdata_a,
    output xlen_t            rdata_b,
    // Retired instruction count
    output instret_t         instret
);

    logic        rf_wen;
    reg_idx_t    rf_wdst;
    xlen_t       rf_wdata;
    retire_cnt_t retire_cnt;

    wb_arbiter wb_arbiter_inst (
        .clk         (clk),
        .rst         (rst),
        .ip_valid    (ip_valid),
        .ip_wb_en    (ip_wb_en),
        .ip_hipri    (ip_hipri),
        .ip_dst      (ip_dst),
        .ip_result   (ip_result),
        .ip_ready    (ip_ready),
        .lsp_valid   (lsp_valid),
        .lsp_wb_en   (lsp_wb_en),
        .lsp_dst     (lsp_dst),
        .lsp_result  (lsp_result),
        .lsp_ready   (lsp_ready),
        .md_valid    (md_valid),
        .md_dst      (md_dst),
        .md_result   (md_result),
        .md_ready    (md_ready),
        .trap_valid  (trap_valid),
        .trap_wb_en  (trap_wb_en),
        .trap_dst    (trap_dst),
        .trap_result (trap_result),
        .trap_ready  (trap_ready),
        .rf_wen      (rf_wen),
        .rf_wdst     (rf_wdst),
        .rf_wdata    (rf_wdata),
        .fwd_valid   (fwd_valid),
        .fwd_dst     (fwd_dst),
        .fwd_value   (fwd_value),
        .retire_cnt  (retire_cnt)
    );

    // Single write port from the arbiter
    reg_file reg_file_inst (
        .clk     (clk),
        .rst     (rst),
        .wen     (rf_wen),
        .wdst    (rf_wdst),
        .wdata   (rf_wdata),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    retire_counter retire_counter_inst (
        .clk        (clk),
        .rst        (rst),
        .retire_cnt (retire_cnt),
        .instret    (instret)
    );

endmodule

`default_nettype wire

// ==== bench/wb_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_stage_tb
    import core_pkg::*;
();

    localparam int    HALF_PERIOD  = 20;
    localparam int    RESET_CYCLES = 5;
    localparam string CASE_FILE    = "bench/wb_cases.txt";

    logic        clk;
    logic        rst;
    logic        ip_valid;
    logic        ip_wb_en;
    logic        ip_hipri;
    reg_idx_t    ip_dst;
    xlen_t       ip_result;
    logic        ip_ready;
    logic        lsp_valid;
    logic        lsp_wb_en;
    reg_idx_t    lsp_dst;
    xlen_t       lsp_result;
    logic        lsp_ready;
    logic        md_valid;
    reg_idx_t    md_dst;
    xlen_t       md_result;
    logic        md_ready;
    logic        trap_valid;
    logic        trap_wb_en;
    reg_idx_t    trap_dst;
    xlen_t       trap_result;
    logic        trap_ready;
    logic        fwd_valid;
    reg_idx_t    fwd_dst;
    xlen_t       fwd_value;
    reg_idx_t    raddr_a;
    reg_idx_t    raddr_b;
    xlen_t       rdata_a;
    xlen_t       rdata_b;
    instret_t    instret;

    // Expected values of one step
    // Readies in the order md lsp ip trap
    string       step_name;
    logic [3:0]  exp_ready;
    logic        exp_fwd_valid;
    reg_idx_t    exp_fwd_dst;
    xlen_t       exp_fwd_value;
    xlen_t       exp_rdata;

    // Registers that some step asked to write
    logic [NUM_REGS-1:0] written;
    instret_t    exp_instret;
    string       cur_test;
    int          test_errs;
    int          tests_ok;
    int          tests_bad;
    int          step_cnt;
    int          cycle_cnt;
    int          cycle_limit;

    wb_stage wb_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Watchdog with a limit set once the step count is known
    initial begin
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the run did not reach its end", cycle_cnt);
        $display("SIMULATION FAILED");
        $finish;
    end

    // Comment and blank lines are skipped
    function automatic bit is_step(input string l);
        return (l.len() > 1) && (l.getc(0) != "#");
    endfunction

    function automatic int count_steps();
        int    f;
        int    n;
        string l;
        n = 0;
        f = $fopen(CASE_FILE, "r");
        if (f == 0) return 0;
        while (!$feof(f)) begin
            if ($fgets(l, f) != 0 && is_step(l)) n++;
        end
        $fclose(f);
        return n;
    endfunction

    task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("ERR %s %s expected %0h actual %0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    // Report the test in progress and open the next one
    task automatic start_test(input string name);
        if (cur_test != "" && test_errs == 0) begin
            tests_ok++;
            $display("test %s ok", cur_test);
        end else if (cur_test != "") begin
            tests_bad++;
            $display("test %s had %0d errors", cur_test, test_errs);
        end
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic drive_idle();
        {md_valid, lsp_valid, lsp_wb_en, ip_valid, ip_wb_en, ip_hipri} = '0;
        {trap_valid, trap_wb_en, md_dst, lsp_dst, ip_dst, trap_dst} = '0;
        {md_result, lsp_result, ip_result, trap_result} = '0;
    endtask

    // One step per cycle with inputs driven on the falling edge
    // Readies are checked before the rising edge and state after it
    task automatic run_step(input string l);
        int n;
        n = $sscanf(l, "%s %d %d %h %d %d %d %h %d %d %d %h %d %d %d %h %d %b %d %d %h %d %h",
                    step_name, md_valid, md_dst, md_result,
                    lsp_valid, lsp_wb_en, lsp_dst, lsp_result,
                    ip_valid, ip_wb_en, ip_dst, ip_result,
                    trap_valid, trap_wb_en, trap_dst, trap_result, ip_hipri,
                    exp_ready, exp_fwd_valid, exp_fwd_dst, exp_fwd_value, raddr_a, exp_rdata);
        if (n != 23) begin
            $display("malformed step line in the case file: %s", l);
            tests_bad++;
            return;
        end
        if (step_name != cur_test) start_test(step_name);
        // Idle payloads carry noise
        if (!md_valid) md_result = {$urandom, $urandom};
        if (!lsp_valid) lsp_result = {$urandom, $urandom};
        if (!ip_valid) ip_result = {$urandom, $urandom};
        if (!trap_valid) trap_result = {$urandom, $urandom};
        if (md_valid) written[md_dst] = 1'b1;
        if (lsp_valid && lsp_wb_en) written[lsp_dst] = 1'b1;
        if (ip_valid && ip_wb_en) written[ip_dst] = 1'b1;
        if (trap_valid && trap_wb_en) written[trap_dst] = 1'b1;
        // Every valid with ready high is one handshake
        exp_instret += instret_t'(md_valid && exp_ready[3]) + instret_t'(lsp_valid && exp_ready[2])
                     + instret_t'(ip_valid && exp_ready[1]) + instret_t'(trap_valid && exp_ready[0]);
        #(HALF_PERIOD - 2);
        compare("md_ready", exp_ready[3], md_ready);
        compare("lsp_ready", exp_ready[2], lsp_ready);
        compare("ip_ready", exp_ready[1], ip_ready);
        compare("trap_ready", exp_ready[0], trap_ready);
        @(posedge clk);
        #1;
        compare("fwd_valid", exp_fwd_valid, fwd_valid);
        if (exp_fwd_valid) begin
            compare("fwd_dst", exp_fwd_dst, fwd_dst);
            compare("fwd_value", exp_fwd_value, fwd_value);
        end
        compare($sformatf("x%0d", raddr_a), exp_rdata, rdata_a);
        compare("x0 on port b", '0, rdata_b);
        @(negedge clk);
    endtask

    initial begin
        int    fd;
        int    seed;
        string line;
        rst = 1'b1;
        drive_idle();
        raddr_a     = '0;
        raddr_b     = '0;
        seed        = $urandom(32'h477b);
        written     = '0;
        exp_instret = '0;
        cur_test    = "";
        test_errs   = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        step_cnt    = count_steps();
        cycle_limit = 4 * step_cnt + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (step_cnt == 0) begin
            $display("no step lines could be read from %s", CASE_FILE);
            tests_bad++;
        end else begin
            fd = $fopen(CASE_FILE, "r");
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0 && is_step(line)) run_step(line);
            end
            $fclose(fd);
            // instret trails the last handshake by two edges
            drive_idle();
            start_test("instret");
            repeat (2) @(posedge clk);
            #1;
            compare("instret", exp_instret, instret);
            // Never-written registers and x0 must still read zero
            start_test("reg_sweep");
            for (int i = 0; i < NUM_REGS; i++) begin
                @(negedge clk);
                raddr_b = reg_idx_t'(i);
                #(HALF_PERIOD - 2);
                if (i == 0 || !written[i]) compare($sformatf("x%0d", i), '0, rdata_b);
            end
            start_test("");
        end
        $display("tests passed %0d, tests failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/core_pkg.sv
logic/wb_arbiter.sv
logic/reg_file.sv
logic/retire_counter.sv
logic/wb_stage.sv
bench/wb_stage_tb.sv

// ==== bench/wb_cases.txt ====
# name | md: v dst res | lsp: v wb_en dst res | ip: v wb_en dst res | trap: v wb_en dst res | hipri
# ready (md lsp ip trap) | fwd_valid fwd_dst fwd_value after the edge | reg index and its value
wr_md    1 5 a5a5  0 0 0 0  0 0 0 0  0 0 0 0  0  1111  0 0 0  5 a5a5
wr_lsp   0 0 0  1 1 6 b6  0 0 0 0  0 0 0 0  0  1111  0 0 0  6 b6
wr_ip    0 0 0  0 0 0 0  1 1 7 c7  0 0 0 0  0  1111  0 0 0  7 c7
wr_trap  0 0 0  0 0 0 0  0 0 0 0  1 1 8 d8  0  1111  0 0 0  8 d8
wr_x0    1 0 ffff  0 0 0 0  0 0 0 0  0 0 0 0  0  1111  0 0 0  0 0
collide  1 9 1009  1 1 10 100a  1 1 11 100b  1 1 12 100c  0  1100  1 10 100a  9 1009
collide  0 0 0  0 0 0 0  1 1 11 100b  1 1 12 100c  0  1110  1 11 100b  10 100a
collide  0 0 0  1 1 13 200d  0 0 0 0  1 1 12 100c  0  1110  1 13 200d  11 100b
collide  0 0 0  0 0 0 0  0 0 0 0  1 1 12 100c  0  1110  0 0 0  13 200d
collide  0 0 0  0 0 0 0  0 0 0 0  1 1 12 100c  0  1111  0 0 0  12 100c
hipri    1 14 300e  1 1 15 300f  1 1 16 3010  0 0 0 0  1  0111  1 15 300f  16 3010
hipri    1 14 300e  0 0 0 0  0 0 0 0  0 0 0 0  0  1111  1 15 300f  14 300e
hipri    0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0  1111  0 0 0  15 300f
fwd_hold 1 17 4011  1 1 18 4012  0 0 0 0  0 0 0 0  0  1111  1 18 4012  17 4011
fwd_hold 1 19 4013  1 1 20 4014  1 1 21 4015  0 0 0 0  0  1001  1 18 4012  19 4013
fwd_hold 0 0 0  1 1 20 4014  1 1 21 4015  0 0 0 0  0  1101  1 20 4014  18 4012
fwd_hold 0 0 0  0 0 0 0  1 1 21 4015  0 0 0 0  0  1111  1 21 4015  20 4014
fwd_hold 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0  1111  0 0 0  21 4015
retire   1 22 5016  1 0 24 5018  1 0 23 5017  1 0 25 5019  0  1111  0 0 0  22 5016
retire   0 0 0  1 1 26 601a  1 0 27 5027  1 0 28 5028  0  1111  0 0 0  23 0
retire   0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0  1111  0 0 0  26 601a
retire   0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0  1111  0 0 0  24 0
retire   0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0  1111  0 0 0  25 0
retire   0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0  1111  0 0 0  27 0
